/* logic/periph_pkg.sv */
// shared address map, widths and bus structs; only 4 full and 2 byte slots exist in this hub
package periph_pkg;

    // bus widths
    localparam int addr_w = 11;
    localparam int data_w = 32;
    localparam int byte_w = 8;
    localparam int pin_w  = 8;

    // local offset widths inside a slot
    localparam int full_off_w   = 6;
    localparam int simple_off_w = 4;

    // slot counts and fixed slot indices
    localparam int n_full        = 4;
    localparam int n_simple      = 2;
    localparam int slot_reserved = 0;
    localparam int slot_gpio     = 1;
    // first external full slot, the rest follow it
    localparam int slot_ext_base = 2;
    localparam int n_ext_full    = n_full - slot_ext_base;

    // addr[10:9] of the byte slot window (0x400 - 0x5ff)
    localparam logic [1:0] simple_class = 2'b10;

    // access size, 3 = idle
    typedef logic [1:0] size_t;
    localparam size_t size_none = 2'b11;

    // bit 2 = byte slot, bits 1:0 = slot index
    typedef logic [2:0] func_sel_t;
    // bit 2 = audio enable, bits 1:0 = tap
    typedef logic [2:0] audio_sel_t;

    // pins 0 and 1 come up on the uart slot, the rest on gpio
    localparam func_sel_t func_reset_uart = 3'b010;
    localparam func_sel_t func_reset_gpio = 3'b001;

    // gpio register offsets
    localparam logic [full_off_w-1:0] off_gpio_out  = 6'h00;
    localparam logic [full_off_w-1:0] off_gpio_in   = 6'h04;
    localparam logic [full_off_w-1:0] off_audio_sel = 6'h10;
    localparam logic [full_off_w-1:0] off_func_base = 6'h20;
    // keeps bit 5 and the byte lane bits of a func select offset
    localparam logic [full_off_w-1:0] off_func_mask = 6'h23;

    // request from the core, 47 bits
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        size_t             write_size;
        size_t             read_size;
    } core_req_t;

    // response to the core, 33 bits
    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              ready;
    } core_rsp_t;

    // full slot request, sizes already gated per slot
    typedef struct packed {
        logic [full_off_w-1:0] offset;
        logic [data_w-1:0]     wdata;
        size_t                 write_size;
        size_t                 read_size;
    } full_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              ready;
    } full_rsp_t;

    // byte slot request
    typedef struct packed {
        logic [simple_off_w-1:0] offset;
        logic [byte_w-1:0]       wdata;
        logic                    write;
    } simple_req_t;

endpackage

/* logic/addr_decode.sv */
// slot decode only; byte window addresses with addr[5:4] beyond the last byte slot select nothing
module addr_decode (
    input  logic [periph_pkg::addr_w-1:0]   addr,
    output logic [periph_pkg::n_full-1:0]   full_sel,
    output logic [periph_pkg::n_simple-1:0] simple_sel,
    output logic                            is_simple
);

    // slot index fields of the address
    logic [1:0] full_idx;
    logic [1:0] simple_idx;

    // byte slots sit in the 0x400 window
    assign is_simple = addr[periph_pkg::addr_w-1 -: 2] == periph_pkg::simple_class;

    // 64-byte full slots
    assign full_idx = addr[7:6];
    // 16-byte byte slots
    assign simple_idx = addr[5:4];

    // one-hot full select
    // anything outside the byte window lands here, 0x600 and up aliases too
    always_comb begin
        full_sel = '0;
        for (int i = 0; i < periph_pkg::n_full; i++) begin
            full_sel[i] = !is_simple && (full_idx == 2'(i));
        end
    end

    // one-hot byte select
    always_comb begin
        simple_sel = '0;
        for (int i = 0; i < periph_pkg::n_simple; i++) begin
            simple_sel[i] = is_simple && (simple_idx == 2'(i));
        end
    end

endmodule

/* logic/slot_mux.sv */
// and-or select; sel must be one-hot or zero, an all-zero select gives an all-zero payload
module slot_mux #(
    parameter type payload_t = logic [31:0],
    parameter int  n         = 4
) (
    input  logic [n-1:0] sel,
    input  payload_t     in [n],
    output payload_t     out
);

    localparam int w = $bits(payload_t);

    logic [w-1:0] acc;

    // no priority, each input masked by its own select bit
    always_comb begin
        acc = '0;
        for (int i = 0; i < n; i++) begin
            acc = acc | (in[i] & {w{sel[i]}});
        end
    end

    assign out = payload_t'(acc);

endmodule

/* logic/read_return.sv */
// read data is held until read_complete; the core must not start a new read before completing
module read_return (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::size_t     read_size,
    input  periph_pkg::size_t     write_size,
    input  periph_pkg::full_rsp_t slot_rsp,
    input  logic                  read_complete,
    output periph_pkg::core_rsp_t rsp,
    output logic                  holding
);

    logic                          read_req;
    logic                          capture;
    logic                          ready_r;
    logic [periph_pkg::data_w-1:0] data_r;

    assign read_req = read_size != periph_pkg::size_none;

    // first ready cycle of a read while nothing is buffered
    assign capture = read_req && slot_rsp.ready && !holding;

    // hold flag and registered ready
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            holding <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            // a new capture beats a stale complete
            if (capture) begin
                holding <= 1'b1;
            end else if (read_complete) begin
                holding <= 1'b0;
            end
            // data is registered, so ready lags the slot by one cycle
            ready_r <= read_req && slot_rsp.ready;
        end
    end

    // held read word
    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= slot_rsp.rdata;
        end
    end

    // writes complete straight away, the slot samples them on the next edge
    assign rsp = '{
        rdata: data_r,
        ready: ready_r || (write_size != periph_pkg::size_none)
    };

endmodule

/* logic/gpio_regs.sv */
// gpio slot registers; writes take only the low bits of wdata, whatever the access size
module gpio_regs (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  sel,
    input  logic [periph_pkg::full_off_w-1:0]     offset,
    input  logic [periph_pkg::data_w-1:0]         wdata,
    input  periph_pkg::size_t                     write_size,
    input  logic [periph_pkg::pin_w-1:0]          ui_in,
    output periph_pkg::full_rsp_t                 rdata,
    output logic [periph_pkg::pin_w-1:0]          gpio_out,
    output periph_pkg::func_sel_t                 func_sel [periph_pkg::pin_w],
    output periph_pkg::audio_sel_t                audio_sel
);

    localparam int idx_w = $clog2(periph_pkg::pin_w);

    logic                          wr_en;
    logic                          func_hit;
    logic [idx_w-1:0]              func_idx;
    logic [periph_pkg::data_w-1:0] rd_word;

    assign wr_en = sel && (write_size != periph_pkg::size_none);

    // func selects are words 0x20 .. 0x3c, one per pin
    assign func_hit = (offset & periph_pkg::off_func_mask) == periph_pkg::off_func_base;
    assign func_idx = offset[idx_w+1:2];

    // output register and audio select
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
        end else if (wr_en) begin
            if (offset == periph_pkg::off_gpio_out) begin
                gpio_out <= wdata[periph_pkg::pin_w-1:0];
            end
            if (offset == periph_pkg::off_audio_sel) begin
                audio_sel <= wdata[2:0];
            end
        end
    end

    // pin function selects
    always_ff @(posedge clk) begin
        for (int i = 0; i < periph_pkg::pin_w; i++) begin
            if (!rst_n) begin
                // uart tx/rx pins
                func_sel[i] <= (i < 2) ? periph_pkg::func_reset_uart : periph_pkg::func_reset_gpio;
            end else if (wr_en && func_hit && (func_idx == idx_w'(i))) begin
                func_sel[i] <= wdata[2:0];
            end
        end
    end

    // readback, unused bits and holes read zero
    always_comb begin
        rd_word = '0;
        if (func_hit) begin
            rd_word[2:0] = func_sel[func_idx];
        end else begin
            case (offset)
                periph_pkg::off_gpio_out:  rd_word[periph_pkg::pin_w-1:0] = gpio_out;
                periph_pkg::off_gpio_in:   rd_word[periph_pkg::pin_w-1:0] = ui_in;
                periph_pkg::off_audio_sel: rd_word[2:0] = audio_sel;
                default: ;
            endcase
        end
    end

    // gpio never stalls
    assign rdata = '{rdata: rd_word, ready: 1'b1};

endmodule

/* logic/pin_router.sv */
// pin routing is combinational; a byte select naming a missing byte slot drives the pin low
module pin_router (
    input  logic                            clk,
    input  logic                            rst_n,
    input  periph_pkg::func_sel_t           func_sel    [periph_pkg::pin_w],
    input  periph_pkg::audio_sel_t          audio_sel,
    input  logic [periph_pkg::pin_w-1:0]    full_pins   [periph_pkg::n_full],
    input  logic [periph_pkg::pin_w-1:0]    simple_pins [periph_pkg::n_simple],
    output logic [periph_pkg::pin_w-1:0]    uo_out,
    output logic                            audio,
    output logic                            audio_select
);

    logic audio_tap;

    // pin i takes bit i of its source
    always_comb begin
        uo_out = '0;
        for (int i = 0; i < periph_pkg::pin_w; i++) begin
            if (func_sel[i][2]) begin
                // only two byte slots, bit 0 is the whole index
                if (func_sel[i][1:0] < 2'(periph_pkg::n_simple)) begin
                    uo_out[i] = simple_pins[func_sel[i][0]][i];
                end
            end else begin
                uo_out[i] = full_pins[func_sel[i][1:0]][i];
            end
        end
    end

    // audio tap choice
    always_comb begin
        case (audio_sel[1:0])
            2'd0:    audio_tap = full_pins[periph_pkg::slot_ext_base][7];
            2'd1:    audio_tap = full_pins[periph_pkg::slot_ext_base + 1][7];
            2'd2:    audio_tap = simple_pins[0][0];
            default: audio_tap = simple_pins[1][7];
        endcase
    end

    // registered, so audio lags the tap by a cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            audio <= 1'b0;
        end else begin
            audio <= audio_tap;
        end
    end

    // enable flag goes straight out
    assign audio_select = audio_sel[2];

endmodule

/* logic/periph_hub.sv */
// peripheral hub; slot 0 is reserved and never ready, so the core must not read it
module periph_hub (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [periph_pkg::pin_w-1:0]      ui_in,
    input  periph_pkg::core_req_t             req,
    input  logic                              read_complete,
    output periph_pkg::core_rsp_t             rsp,
    output periph_pkg::full_req_t             full_req     [periph_pkg::n_ext_full],
    input  periph_pkg::full_rsp_t             full_rsp     [periph_pkg::n_ext_full],
    input  logic [periph_pkg::pin_w-1:0]      full_pins    [periph_pkg::n_ext_full],
    output periph_pkg::simple_req_t           simple_req   [periph_pkg::n_simple],
    input  logic [periph_pkg::byte_w-1:0]     simple_rdata [periph_pkg::n_simple],
    input  logic [periph_pkg::pin_w-1:0]      simple_pins  [periph_pkg::n_simple],
    output logic [periph_pkg::pin_w-1:0]      uo_out,
    output logic                              audio,
    output logic                              audio_select
);

    logic [periph_pkg::n_full-1:0]   full_sel;
    logic [periph_pkg::n_simple-1:0] simple_sel;
    logic                            is_simple;
    logic                            holding;
    logic                            block_read;

    // per full slot view, reserved and gpio included
    periph_pkg::full_rsp_t           slot_full_rsp  [periph_pkg::n_full];
    logic [periph_pkg::pin_w-1:0]    slot_full_pins [periph_pkg::n_full];

    periph_pkg::full_rsp_t           full_mux_rsp;
    logic [periph_pkg::byte_w-1:0]   simple_mux_rdata;
    periph_pkg::full_rsp_t           slot_rsp;

    logic [periph_pkg::pin_w-1:0]    gpio_out;
    periph_pkg::func_sel_t           func_sel [periph_pkg::pin_w];
    periph_pkg::audio_sel_t          audio_sel;

    addr_decode u_decode (
        .addr       (req.addr),
        .full_sel   (full_sel),
        .simple_sel (simple_sel),
        .is_simple  (is_simple)
    );

    // no second read reaches a slot while a result is buffered
    assign block_read = holding || rsp.ready;

    // reserved slot reads zero, never ready
    assign slot_full_rsp[periph_pkg::slot_reserved]  = '0;
    assign slot_full_pins[periph_pkg::slot_reserved] = '0;
    assign slot_full_pins[periph_pkg::slot_gpio]     = gpio_out;

    // external full slots, sizes gated to idle unless selected
    for (genvar i = 0; i < periph_pkg::n_ext_full; i++) begin : g_ext_full
        localparam int s = periph_pkg::slot_ext_base + i;

        assign slot_full_rsp[s]  = full_rsp[i];
        assign slot_full_pins[s] = full_pins[i];
        assign full_req[i] = '{
            offset:     req.addr[periph_pkg::full_off_w-1:0],
            wdata:      req.wdata,
            write_size: full_sel[s] ? req.write_size : periph_pkg::size_none,
            read_size:  (full_sel[s] && !block_read) ? req.read_size : periph_pkg::size_none
        };
    end

    // byte slots only see a write strobe
    for (genvar j = 0; j < periph_pkg::n_simple; j++) begin : g_simple
        assign simple_req[j] = '{
            offset: req.addr[periph_pkg::simple_off_w-1:0],
            wdata:  req.wdata[periph_pkg::byte_w-1:0],
            write:  simple_sel[j] && (req.write_size != periph_pkg::size_none)
        };
    end

    gpio_regs u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (full_sel[periph_pkg::slot_gpio]),
        .offset     (req.addr[periph_pkg::full_off_w-1:0]),
        .wdata      (req.wdata),
        .write_size (req.write_size),
        .ui_in      (ui_in),
        .rdata      (slot_full_rsp[periph_pkg::slot_gpio]),
        .gpio_out   (gpio_out),
        .func_sel   (func_sel),
        .audio_sel  (audio_sel)
    );

    slot_mux #(
        .payload_t (periph_pkg::full_rsp_t),
        .n         (periph_pkg::n_full)
    ) u_full_mux (
        .sel (full_sel),
        .in  (slot_full_rsp),
        .out (full_mux_rsp)
    );

    slot_mux #(
        .payload_t (logic [periph_pkg::byte_w-1:0]),
        .n         (periph_pkg::n_simple)
    ) u_simple_mux (
        .sel (simple_sel),
        .in  (simple_rdata),
        .out (simple_mux_rdata)
    );

    // byte slots are always ready, data zero-extended
    always_comb begin
        if (is_simple) begin
            slot_rsp.rdata = {{(periph_pkg::data_w - periph_pkg::byte_w){1'b0}}, simple_mux_rdata};
            slot_rsp.ready = 1'b1;
        end else begin
            slot_rsp = full_mux_rsp;
        end
    end

    read_return u_return (
        .clk           (clk),
        .rst_n         (rst_n),
        .read_size     (req.read_size),
        .write_size    (req.write_size),
        .slot_rsp      (slot_rsp),
        .read_complete (read_complete),
        .rsp           (rsp),
        .holding       (holding)
    );

    pin_router u_router (
        .clk          (clk),
        .rst_n        (rst_n),
        .func_sel     (func_sel),
        .audio_sel    (audio_sel),
        .full_pins    (slot_full_pins),
        .simple_pins  (simple_pins),
        .uo_out       (uo_out),
        .audio        (audio),
        .audio_select (audio_select)
    );

endmodule

/* test/hub_checker.sv */
// compares hub outputs at rising edges only; a read must show ready within 20 cycles
module hub_checker (
    input  logic                              clk,
    input  periph_pkg::core_rsp_t             rsp,
    input  periph_pkg::full_req_t             full_req   [periph_pkg::n_ext_full],
    input  periph_pkg::simple_req_t           simple_req [periph_pkg::n_simple],
    input  logic [periph_pkg::pin_w-1:0]      uo_out,
    input  logic                              audio,
    input  logic                              audio_select,
    input  logic                              cmd_valid,
    input  logic [7:0]                        cmd_op,
    input  logic [periph_pkg::addr_w-1:0]     cmd_addr,
    input  logic [31:0]                       cmd_data,
    input  logic [31:0]                       cmd_exp,
    input  int                                cmd_delay,
    output int                                done_seq,
    output int                                mismatches,
    output int                                protocol_errors
);

    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        done_seq        = 0;
        mismatches      = 0;
        protocol_errors = 0;
    end

    // one value against its expected value
    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // external full slot i sits outside the 0x400 byte window at addr[7:6] = 2 + i
    function automatic logic ext_full_addressed(input int i);
        return (cmd_addr[10:9] != 2'b10) && (cmd_addr[7:6] == 2'(i + 2));
    endfunction

    // write is acknowledged at once, only the addressed external slot sees it
    // cmd_exp bits 1:0 are full slots 2 and 3, bits 3:2 the byte slots
    task automatic check_write();
        compare("rsp.ready", rsp.ready, 1);
        for (int i = 0; i < periph_pkg::n_ext_full; i++) begin
            compare($sformatf("full_req[%0d].write_size", i), full_req[i].write_size,
                    cmd_exp[i] ? 2 : 3);
            compare($sformatf("full_req[%0d].read_size", i), full_req[i].read_size, 3);
            // written slot gets its local offset and the whole word
            if (cmd_exp[i]) begin
                compare($sformatf("full_req[%0d].offset", i), full_req[i].offset,
                        cmd_addr[5:0]);
                compare($sformatf("full_req[%0d].wdata", i), full_req[i].wdata, cmd_data);
            end
        end
        for (int j = 0; j < periph_pkg::n_simple; j++) begin
            compare($sformatf("simple_req[%0d].write", j), simple_req[j].write, cmd_exp[2 + j]);
            // byte slots take a 4-bit offset and the low byte
            if (cmd_exp[2 + j]) begin
                compare($sformatf("simple_req[%0d].offset", j), simple_req[j].offset,
                        cmd_addr[3:0]);
                compare($sformatf("simple_req[%0d].wdata", j), simple_req[j].wdata,
                        cmd_data[7:0]);
            end
        end
    endtask

    // ready one cycle after the request, then data held for cmd_delay cycles
    task automatic check_read();
        int cycles;
        cycles = 0;
        // before capture only the addressed external slot sees the read
        for (int i = 0; i < periph_pkg::n_ext_full; i++) begin
            compare($sformatf("full_req[%0d].read_size", i), full_req[i].read_size,
                    ext_full_addressed(i) ? 2 : 3);
        end
        while (!rsp.ready && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!rsp.ready) begin
            protocol_errors++;
            $display("read at %0t ns got no ready from the hub within 20 cycles", $time);
        end else begin
            compare("cycles to rsp.ready", cycles, 1);
            compare("rsp.rdata", rsp.rdata, cmd_exp);
            // buffered result blocks any second read to the slots
            for (int i = 0; i < periph_pkg::n_ext_full; i++) begin
                compare($sformatf("full_req[%0d].read_size", i), full_req[i].read_size, 3);
            end
            // model data is scrambled meanwhile, so only the held word matches
            for (int k = 0; k < cmd_delay; k++) begin
                @(posedge clk);
                compare("rsp.rdata held", rsp.rdata, cmd_exp);
            end
        end
    endtask

    // enable is immediate, audio shows the tap one edge later
    task automatic check_audio();
        compare("audio_select", audio_select, cmd_exp[1]);
        @(posedge clk);
        compare("audio", audio, cmd_exp[0]);
    endtask

    // one command per valid, done_seq tells the bench it is finished
    always @(posedge clk) begin
        if (cmd_valid) begin
            case (cmd_op)
                "W": check_write();
                "R": check_read();
                "P": compare("uo_out", uo_out, cmd_exp);
                "A": check_audio();
                default: begin
                    protocol_errors++;
                    $display("unknown operation code %h in a golden vector", cmd_op);
                end
            endcase
            done_seq++;
        end
    end

endmodule

/* test/tb_periph_hub.sv */
// replays test/hub_golden.txt from the project root; external slots are ideal models
module tb_periph_hub;

    timeunit 1ns;
    timeprecision 1ns;

    logic                              clk;
    logic                              rst_n;
    logic [periph_pkg::pin_w-1:0]      ui_in;
    periph_pkg::core_req_t             req;
    logic                              read_complete;
    periph_pkg::core_rsp_t             rsp;
    periph_pkg::full_req_t             full_req     [periph_pkg::n_ext_full];
    periph_pkg::full_rsp_t             full_rsp     [periph_pkg::n_ext_full];
    logic [periph_pkg::pin_w-1:0]      full_pins    [periph_pkg::n_ext_full];
    periph_pkg::simple_req_t           simple_req   [periph_pkg::n_simple];
    logic [periph_pkg::byte_w-1:0]     simple_rdata [periph_pkg::n_simple];
    logic [periph_pkg::pin_w-1:0]      simple_pins  [periph_pkg::n_simple];
    logic [periph_pkg::pin_w-1:0]      uo_out;
    logic                              audio;
    logic                              audio_select;

    // slot model patterns from the current vector
    logic [31:0]                       ext_word  [periph_pkg::n_ext_full];
    logic [7:0]                        byte_word [periph_pkg::n_simple];
    // inverts model read data once a read is captured
    logic                              scramble;

    // checker commands
    logic                              cmd_valid;
    logic [7:0]                        cmd_op;
    logic [periph_pkg::addr_w-1:0]     cmd_addr;
    logic [31:0]                       cmd_data;
    logic [31:0]                       cmd_exp;
    int                                cmd_delay;
    int                                done_seq;
    int                                mismatches;
    int                                protocol_errors;
    int                                ops;
    logic                              stuck;

    periph_hub UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .ui_in         (ui_in),
        .req           (req),
        .read_complete (read_complete),
        .rsp           (rsp),
        .full_req      (full_req),
        .full_rsp      (full_rsp),
        .full_pins     (full_pins),
        .simple_req    (simple_req),
        .simple_rdata  (simple_rdata),
        .simple_pins   (simple_pins),
        .uo_out        (uo_out),
        .audio         (audio),
        .audio_select  (audio_select)
    );

    hub_checker u_checker (
        .clk             (clk),
        .rsp             (rsp),
        .full_req        (full_req),
        .simple_req      (simple_req),
        .uo_out          (uo_out),
        .audio           (audio),
        .audio_select    (audio_select),
        .cmd_valid       (cmd_valid),
        .cmd_op          (cmd_op),
        .cmd_addr        (cmd_addr),
        .cmd_data        (cmd_data),
        .cmd_exp         (cmd_exp),
        .cmd_delay       (cmd_delay),
        .done_seq        (done_seq),
        .mismatches      (mismatches),
        .protocol_errors (protocol_errors)
    );

    // full slots answer in the same cycle, pins are the word's low byte
    for (genvar i = 0; i < periph_pkg::n_ext_full; i++) begin : g_full_model
        assign full_rsp[i]  = '{rdata: scramble ? ~ext_word[i] : ext_word[i], ready: 1'b1};
        assign full_pins[i] = ext_word[i][periph_pkg::pin_w-1:0];
    end

    for (genvar j = 0; j < periph_pkg::n_simple; j++) begin : g_byte_model
        assign simple_rdata[j] = scramble ? ~byte_word[j] : byte_word[j];
        assign simple_pins[j]  = byte_word[j];
    end

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // apply one vector on a falling edge, wait for the checker, then idle a cycle
    task automatic run_op(input logic [7:0] op, input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] e2, input logic [31:0] e3, input logic [31:0] b0,
                          input logic [31:0] b1, input logic [31:0] exp, input int delay);
        int start_seq;
        int cycles;
        ext_word[0]    = e2;
        ext_word[1]    = e3;
        byte_word[0]   = b0[7:0];
        byte_word[1]   = b1[7:0];
        req.addr       = addr[periph_pkg::addr_w-1:0];
        req.wdata      = data;
        req.write_size = (op == "W") ? 2'd2 : periph_pkg::size_none;
        req.read_size  = (op == "R") ? 2'd2 : periph_pkg::size_none;
        // data column is the gpio input on reads
        if (op == "R") begin
            ui_in = data[periph_pkg::pin_w-1:0];
        end
        cmd_op    = op;
        cmd_addr  = addr[periph_pkg::addr_w-1:0];
        cmd_data  = data;
        cmd_exp   = exp;
        cmd_delay = delay;
        start_seq = done_seq;
        cmd_valid = 1'b1;
        cycles    = 0;
        while (done_seq == start_seq && cycles < 40) begin
            @(negedge clk);
            cycles++;
            scramble = (op == "R");
        end
        if (done_seq == start_seq) begin
            stuck = 1'b1;
            $display("checker did not finish operation %s at address %h within 40 cycles",
                     op, addr);
        end
        cmd_valid      = 1'b0;
        scramble       = 1'b0;
        req.write_size = periph_pkg::size_none;
        req.read_size  = periph_pkg::size_none;
        read_complete  = (op == "R");
        @(negedge clk);
        read_complete  = 1'b0;
    endtask

    initial begin : main
        int          fd;
        int          n;
        string       line;
        logic [63:0] op_txt;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] e2;
        logic [31:0] e3;
        logic [31:0] b0;
        logic [31:0] b1;
        logic [31:0] exp;
        int          delay;
        rst_n         = 1'b0;
        ui_in         = '0;
        req           = '{addr: '0, wdata: '0, write_size: periph_pkg::size_none,
                          read_size: periph_pkg::size_none};
        read_complete = 1'b0;
        ext_word[0]   = '0;
        ext_word[1]   = '0;
        byte_word[0]  = '0;
        byte_word[1]  = '0;
        scramble      = 1'b0;
        cmd_valid     = 1'b0;
        cmd_op        = '0;
        cmd_addr      = '0;
        cmd_data      = '0;
        cmd_exp       = '0;
        cmd_delay     = 0;
        ops           = 0;
        stuck         = 1'b0;
        // 8 rising edges in reset
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("test/hub_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/hub_golden.txt");
        end else begin
            while (!stuck && $fgets(line, fd) != 0) begin
                // comment and blank lines do not scan all nine fields
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %d",
                            op_txt, addr, data, e2, e3, b0, b1, exp, delay);
                if (n == 9) begin
                    run_op(op_txt[7:0], addr, data, e2, e3, b0, b1, exp, delay);
                    ops++;
                end
            end
            $fclose(fd);
        end
        if (ops == 0) begin
            $display("no vectors were run from the golden file");
        end
        $display("%0d vectors, %0d mismatches, %0d other failures",
                 ops, mismatches, protocol_errors + stuck);
        if (ops > 0 && !stuck && mismatches == 0 && protocol_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* test/hub_golden.txt */
# op addr data ext2_word ext3_word byte0 byte1 expected hold; data is ui_in on reads
# expected: R rdata, P uo_out, A {audio_select,audio}, W write mask {byte1,byte0,full3,full2}
P 000 00000000 89abcd57 13572468 3c c6 00000003 0
A 000 00000000 89abcd57 13572468 3c c6 00000000 0
R 060 00000000 89abcd57 13572468 3c c6 00000002 0
R 064 00000000 89abcd57 13572468 3c c6 00000002 0
R 068 00000000 89abcd57 13572468 3c c6 00000001 0
R 07c 00000000 89abcd57 13572468 3c c6 00000001 0
W 040 000000a6 89abcd57 13572468 3c c6 00000000 0
R 040 00000000 89abcd57 13572468 3c c6 000000a6 0
R 044 0000005a 89abcd57 13572468 3c c6 0000005a 0
P 000 00000000 89abcd57 13572468 3c c6 000000a7 0
R 080 00000000 89abcd57 13572468 3c c6 89abcd57 0
R 0c0 00000000 89abcd57 13572468 3c c6 13572468 3
R 400 00000000 89abcd57 13572468 3c c6 0000003c 0
R 414 00000000 89abcd57 13572468 3c c6 000000c6 2
W 068 00000004 89abcd57 13572468 3c c6 00000000 0
W 07c 00000003 89abcd57 13572468 3c c6 00000000 0
W 060 00000005 89abcd57 13572468 3c c6 00000000 0
W 06c 00000000 89abcd57 13572468 3c c6 00000000 0
P 000 00000000 89abcd57 13572468 3c c6 00000026 0
P 000 00000000 89abcd57 135724e8 3c c7 000000a7 0
R 068 00000000 89abcd57 13572468 3c c6 00000004 0
W 050 00000004 89abcd57 13572468 3c c6 00000000 0
A 000 00000000 89abcdd7 13572468 3c 46 00000003 0
W 050 00000005 89abcd57 13572468 3c c6 00000000 0
A 000 00000000 89abcdd7 13572468 3d c6 00000002 0
W 050 00000006 89abcd57 13572468 3c c6 00000000 0
A 000 00000000 89abcd57 13572468 3d 46 00000003 0
W 050 00000007 89abcd57 13572468 3c c6 00000000 0
A 000 00000000 89abcdd7 135724e8 3d 46 00000002 0
R 050 00000000 89abcd57 13572468 3c c6 00000007 0
W 080 00000011 89abcd57 13572468 3c c6 00000001 0
W 0c4 00000022 89abcd57 13572468 3c c6 00000002 0
W 408 00000033 89abcd57 13572468 3c c6 00000004 0
W 41c 00000044 89abcd57 13572468 3c c6 00000008 0
W 000 00000055 89abcd57 13572468 3c c6 00000000 0

/* periph_hub.f */
logic/periph_pkg.sv
logic/addr_decode.sv
logic/slot_mux.sv
logic/read_return.sv
logic/gpio_regs.sv
logic/pin_router.sv
logic/periph_hub.sv
test/hub_checker.sv
test/tb_periph_hub.sv
